//--- sim.f
+incdir+include
rtl/isa_pkg.sv
rtl/rs_pkg.sv
rtl/rs_row_if.sv
rtl/rs_dispatch.sv
rtl/rs_entry.sv
rtl/rs_issue_select.sv
rtl/reservation_station.sv
testbench/tb_reservation_station.sv

//--- Makefile
# Verilator build for the reservation station testbench

VERILATOR  = verilator
SIM_FLAGS  = --binary --timing -j 0
LINT_FLAGS = --lint-only --timing
TOP        = tb_reservation_station
FILELIST   = sim.f
BUILD_DIR  = obj_dir
LOG        = sim.log
PASS_TEXT  = All tests passed!

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- testbench/tb_reservation_station.sv
/*
 * Testbench for the reservation station.
 * A cycle model of row occupancy predicts every issue slot and rs_full.
 * Directed tests cover latency, wakeup, order, capacity and MEM stall.
 */

`timescale 1ns/10ps
`default_nettype none

`include "rs_config.svh"

module tb_reservation_station;

	logic clock = 1'b0;
	logic reset = 1'b1;
	logic dispatch_valid = 1'b0;
	rs_pkg::dispatch_t dispatch_in = '0;
	logic cdb_valid = 1'b0;
	isa_pkg::preg_t cdb_tag = '0;
	logic mem_stall = 1'b0;
	logic [`NUM_FU-1:0] issue_valid;
	rs_pkg::issue_t issue_slot [`NUM_FU];
	logic rs_full;

	// Reference model state
	logic [`RS_SIZE-1:0] m_busy;
	logic [`RS_SIZE-1:0] m_ok1;
	logic [`RS_SIZE-1:0] m_ok2;
	rs_pkg::dispatch_t m_rec [`RS_SIZE];
	logic [`NUM_FU-1:0] exp_valid;
	rs_pkg::issue_t exp_slot [`NUM_FU];
	int errors = 0;
	int dispatched = 0;
	int issued = 0;
	string test_name = "reset";

	reservation_station reservation_station_i (.*);

	always #20 clock = ~clock;

	// ------------------------------------------------------------------
	// Reference model following the station rules
	// ------------------------------------------------------------------

	always @(posedge clock) begin : model
		int pick;
		int free;
		logic [`RS_SIZE-1:0] granted;
		if (reset) begin
			m_busy = '0;
			exp_valid = '0;
		end else begin
			granted = '0;
			// Lowest ready row per class with MEM held by the stall
			for (int c = 0; c < `NUM_FU; c++) begin
				pick = -1;
				for (int i = `RS_SIZE - 1; i >= 0; i--) begin
					if (m_busy[i] && m_ok1[i] && m_ok2[i] &&
							m_rec[i].fu == isa_pkg::fu_class_t'(c) &&
							!(c == int'(isa_pkg::MEM) && mem_stall)) begin
						pick = i;
					end
				end
				exp_valid[c] = (pick >= 0);
				if (pick >= 0) begin
					exp_slot[c] = '{opcode: m_rec[pick].opcode, dest: m_rec[pick].dest,
						src1: m_rec[pick].src1, src2: m_rec[pick].src2};
					granted[pick] = 1'b1;
				end
			end
			// CDB wakeup of occupied rows
			for (int i = 0; i < `RS_SIZE; i++) begin
				if (m_busy[i] && cdb_valid && cdb_tag == m_rec[i].src1) m_ok1[i] = 1'b1;
				if (m_busy[i] && cdb_valid && cdb_tag == m_rec[i].src2) m_ok2[i] = 1'b1;
			end
			free = -1;
			for (int i = `RS_SIZE - 1; i >= 0; i--) begin
				if (!m_busy[i]) free = i;
			end
			// Dispatch into the lowest free row where a same-cycle CDB hit counts
			if (dispatch_valid && free >= 0) begin
				m_busy[free] = 1'b1;
				m_rec[free] = dispatch_in;
				m_ok1[free] = dispatch_in.src1_ready |
					(cdb_valid && cdb_tag == dispatch_in.src1);
				m_ok2[free] = dispatch_in.src2_ready |
					(cdb_valid && cdb_tag == dispatch_in.src2);
				dispatched++;
			end
			m_busy = m_busy & ~granted;
		end
	end

	task automatic report_mismatch(input string what, input logic [31:0] want,
			input logic [31:0] got);
		errors++;
		$display("Fail %s: %s expected 0x%0h actual 0x%0h", test_name, what, want, got);
	endtask

	// Outputs are settled by the falling edge
	always @(negedge clock) begin : compare_outputs
		if (!reset) begin
			for (int c = 0; c < `NUM_FU; c++) begin
				assert (issue_valid[c] == exp_valid[c])
					else report_mismatch($sformatf("issue_valid[%0d]", c),
						exp_valid[c], issue_valid[c]);
				assert (!exp_valid[c] || issue_slot[c] == exp_slot[c])
					else report_mismatch($sformatf("issue_slot[%0d]", c),
						exp_slot[c], issue_slot[c]);
				if (issue_valid[c]) issued++;
			end
			assert (rs_full == &m_busy) else report_mismatch("rs_full", &m_busy, rs_full);
		end
	end

	// ------------------------------------------------------------------
	// Stimulus helpers
	// ------------------------------------------------------------------

	function automatic rs_pkg::dispatch_t make_record(input isa_pkg::fu_class_t fu,
			input isa_pkg::opcode_t op, input int dest, input int s1, input int s2,
			input logic r1, input logic r2);
		rs_pkg::dispatch_t rec;
		rec.fu = fu;
		rec.opcode = op;
		rec.dest = isa_pkg::preg_t'(dest);
		rec.src1 = isa_pkg::preg_t'(s1);
		rec.src2 = isa_pkg::preg_t'(s2);
		rec.src1_ready = r1;
		rec.src2_ready = r2;
		return rec;
	endfunction

	// Wait for the next edge and drop the strobes 2 ns later
	task automatic step();
		@(posedge clock);
		#2;
		dispatch_valid = 1'b0;
		cdb_valid = 1'b0;
	endtask

	task automatic dispatch_op(input rs_pkg::dispatch_t rec);
		dispatch_valid = 1'b1;
		dispatch_in = rec;
	endtask

	task automatic broadcast(input int tag);
		cdb_valid = 1'b1;
		cdb_tag = isa_pkg::preg_t'(tag);
	endtask

	// Count edges until the slot fires
	task automatic expect_issue(input int cls, input isa_pkg::opcode_t op, input int want);
		int n;
		n = 0;
		do begin
			step();
			n++;
		end while (!issue_valid[cls] && n < 20);
		if (!issue_valid[cls]) begin
			errors++;
			$display("Timed out in %s waiting for issue on slot %0d", test_name, cls);
		end else begin
			assert (n == want) else report_mismatch("issue latency", want, n);
			assert (issue_slot[cls].opcode == op)
				else report_mismatch("opcode", op, issue_slot[cls].opcode);
		end
	endtask

	// Wake every tag and wait for an empty station
	task automatic drain();
		int n;
		mem_stall = 1'b0;
		for (int t = 0; t < 64; t++) begin
			broadcast(t);
			step();
		end
		n = 0;
		while ((m_busy != '0 || issue_valid != '0) && n < 50) begin
			step();
			n++;
		end
		if (m_busy != '0) begin
			errors++;
			$display("Timed out in %s waiting for the station to empty", test_name);
		end
	endtask

	initial begin
		void'($urandom(32'h6c7d0396));
		repeat (4) @(posedge clock);
		#2;
		reset = 1'b0;

		test_name = "ready dispatch";
		assert (issue_valid == '0 && !rs_full) else begin
			errors++;
			$display("Outputs not idle after reset");
		end
		dispatch_op(make_record(isa_pkg::ALU, 8'h11, 1, 2, 3, 1'b1, 1'b1));
		expect_issue(int'(isa_pkg::ALU), 8'h11, 2);

		test_name = "wakeup";
		dispatch_op(make_record(isa_pkg::ALU, 8'h21, 4, 11, 12, 1'b0, 1'b0));
		step();
		broadcast(11);
		repeat (3) begin
			step();
			assert (!issue_valid[0]) else report_mismatch("early issue", 0, 1);
		end
		broadcast(12);
		expect_issue(int'(isa_pkg::ALU), 8'h21, 2);
		// Tag on the CDB in the dispatch cycle
		dispatch_op(make_record(isa_pkg::MULT, 8'h22, 5, 13, 14, 1'b0, 1'b1));
		broadcast(13);
		expect_issue(int'(isa_pkg::MULT), 8'h22, 2);

		test_name = "selection order";
		for (int i = 0; i < 5; i++) begin
			dispatch_op(make_record(i < 3 ? isa_pkg::ALU : isa_pkg::MULT,
				8'h30 + i, i, 10, 0, 1'b0, 1'b1));
			step();
		end
		broadcast(10);
		step();
		step();
		for (int k = 0; k < 3; k++) begin
			assert (issue_valid[0] && issue_slot[0].opcode == 8'h30 + k)
				else report_mismatch("alu order", 8'h30 + k, issue_slot[0].opcode);
			assert (issue_valid[1] == (k < 2))
				else report_mismatch("mult parallel", k < 2, issue_valid[1]);
			step();
		end

		test_name = "capacity";
		for (int i = 0; i < `RS_SIZE; i++) begin
			dispatch_op(make_record(isa_pkg::ALU, 8'h40 + i, i, 20 + i, 0, 1'b0, 1'b1));
			step();
		end
		assert (rs_full) else report_mismatch("rs_full after fill", 1, rs_full);
		broadcast(23);
		step();
		assert (rs_full) else report_mismatch("rs_full in grant cycle", 1, rs_full);
		step();
		assert (!rs_full) else report_mismatch("rs_full after grant", 0, rs_full);
		// The only free row gets refilled here
		dispatch_op(make_record(isa_pkg::MEM, 8'h48, 9, 40, 0, 1'b0, 1'b1));
		step();
		assert (rs_full) else report_mismatch("rs_full after reuse", 1, rs_full);
		drain();

		test_name = "memory stall";
		mem_stall = 1'b1;
		dispatch_op(make_record(isa_pkg::MEM, 8'h70, 1, 0, 0, 1'b1, 1'b1));
		step();
		dispatch_op(make_record(isa_pkg::MEM, 8'h71, 2, 0, 0, 1'b1, 1'b1));
		step();
		// First MEM row has been ready for a full cycle by now
		assert (!issue_valid[2]) else report_mismatch("mem held", 0, 1);
		dispatch_op(make_record(isa_pkg::ALU, 8'h72, 3, 0, 0, 1'b1, 1'b1));
		expect_issue(int'(isa_pkg::ALU), 8'h72, 2);
		dispatch_op(make_record(isa_pkg::MULT, 8'h73, 4, 0, 0, 1'b1, 1'b1));
		expect_issue(int'(isa_pkg::MULT), 8'h73, 2);
		mem_stall = 1'b0;
		expect_issue(int'(isa_pkg::MEM), 8'h70, 1);
		expect_issue(int'(isa_pkg::MEM), 8'h71, 1);

		test_name = "random run";
		for (int k = 0; k < 800; k++) begin
			if (!rs_full && $urandom_range(0, 1) == 1) begin
				dispatch_op(make_record(isa_pkg::fu_class_t'($urandom_range(0, 2)),
					isa_pkg::opcode_t'($urandom), $urandom_range(0, 63),
					$urandom_range(0, 15), $urandom_range(0, 15),
					$urandom_range(0, 3) != 0, $urandom_range(0, 3) != 0));
			end
			if ($urandom_range(0, 1) == 1) broadcast($urandom_range(0, 15));
			mem_stall = ($urandom_range(0, 7) == 0);
			step();
		end
		drain();
		assert (issued == dispatched) else report_mismatch("issued count", dispatched, issued);

		$display("Errors: %0d, dispatched: %0d, issued: %0d", errors, dispatched, issued);
		if (errors == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- rtl/reservation_station.sv
/*
 * Reservation station top level.
 * Takes renamed instructions and CDB broadcasts, issues ready
 * instructions on one slot per unit class.
 */

`timescale 1ns/10ps
`default_nettype none

`include "rs_config.svh"

module reservation_station (
	input  logic               clock,
	input  logic               reset,
	input  logic               dispatch_valid,
	input  rs_pkg::dispatch_t  dispatch_in,
	input  logic               cdb_valid,
	input  isa_pkg::preg_t     cdb_tag,
	input  logic               mem_stall,
	output logic [`NUM_FU-1:0] issue_valid,
	output rs_pkg::issue_t     issue_slot [`NUM_FU],
	output logic               rs_full
);

	// Per-row vectors shared by the three blocks
	rs_row_if row_bus ();

	// Lowest free row and full flag
	rs_dispatch dispatch_i (
		.dispatch_valid (dispatch_valid),
		.rs_full        (rs_full),
		.rows           (row_bus.alloc)
	);

	// ----------------------------------------------------------------------
	// Station rows
	// ----------------------------------------------------------------------

	for (genvar i = 0; i < `RS_SIZE; i++) begin : g_entry
		rs_entry entry_i (
			.clock       (clock),
			.reset       (reset),
			.write       (row_bus.write[i]),
			.dispatch_in (dispatch_in),
			.cdb_valid   (cdb_valid),
			.cdb_tag     (cdb_tag),
			.grant       (row_bus.grant[i]),
			.busy        (row_bus.busy[i]),
			.ready       (row_bus.ready[i]),
			.fu          (row_bus.fu[i]),
			.row         (row_bus.row[i])
		);
	end

	// Per-class pick and issue registers
	rs_issue_select issue_select_i (
		.clock       (clock),
		.reset       (reset),
		.mem_stall   (mem_stall),
		.rows        (row_bus.select),
		.issue_valid (issue_valid),
		.issue_slot  (issue_slot)
	);

endmodule

`default_nettype wire

//--- rtl/rs_issue_select.sv
/*
 * Issue selector of the reservation station.
 * Grants the lowest ready row of each unit class and registers the chosen
 * rows into one issue slot per class. MEM issue is held off by mem_stall.
 */

`timescale 1ns/10ps
`default_nettype none

`include "rs_config.svh"

module rs_issue_select (
	input  logic               clock,
	input  logic               reset,
	input  logic               mem_stall,
	rs_row_if.select           rows,
	output logic [`NUM_FU-1:0] issue_valid,
	output rs_pkg::issue_t     issue_slot [`NUM_FU]
);

	// Ready rows split by class
	logic [`RS_SIZE-1:0] request [`NUM_FU];
	// Lowest requesting row per class, one-hot
	logic [`RS_SIZE-1:0] pick [`NUM_FU];
	// Chosen row contents ahead of the slot registers
	rs_pkg::issue_t slot_next [`NUM_FU];

	// ----------------------------------------------------------------------
	// Request vectors
	// ----------------------------------------------------------------------

	always_comb begin
		for (int c = 0; c < `NUM_FU; c++) begin
			for (int i = 0; i < `RS_SIZE; i++) begin
				request[c][i] = rows.ready[i] && (rows.fu[i] == isa_pkg::fu_class_t'(c));
			end
		end
		// Memory back-pressure, other classes keep going
		if (mem_stall) begin
			request[int'(isa_pkg::MEM)] = '0;
		end
	end

	// ----------------------------------------------------------------------
	// Per-class pick, grants and slot mux
	// ----------------------------------------------------------------------

	always_comb begin
		rows.grant = '0;
		for (int c = 0; c < `NUM_FU; c++) begin
			// Lower rows win
			pick[c] = request[c] & (~request[c] + 1'b1);
			rows.grant = rows.grant | pick[c];
			slot_next[c] = '0;
			for (int i = 0; i < `RS_SIZE; i++) begin
				if (pick[c][i]) begin
					slot_next[c] = rows.row[i];
				end
			end
		end
	end

	// ----------------------------------------------------------------------
	// Issue registers
	// ----------------------------------------------------------------------

	always_ff @(posedge clock) begin
		if (reset) begin
			issue_valid <= '0;
		end else begin
			for (int c = 0; c < `NUM_FU; c++) begin
				issue_valid[c] <= |pick[c];
			end
		end
	end

	// Slot contents only load on a grant
	always_ff @(posedge clock) begin
		for (int c = 0; c < `NUM_FU; c++) begin
			if (|pick[c]) begin
				issue_slot[c] <= slot_next[c];
			end
		end
	end

endmodule

`default_nettype wire

//--- rtl/rs_entry.sv
/*
 * One reservation station row.
 * Holds a renamed instruction, snoops the CDB for its source tags and
 * reports itself ready once both sources are available.
 */

`timescale 1ns/10ps
`default_nettype none

module rs_entry (
	input  logic               clock,
	input  logic               reset,
	input  logic               write,
	input  rs_pkg::dispatch_t  dispatch_in,
	input  logic               cdb_valid,
	input  isa_pkg::preg_t     cdb_tag,
	input  logic               grant,
	output logic               busy,
	output logic               ready,
	output isa_pkg::fu_class_t fu,
	output rs_pkg::issue_t     row
);

	// Stored instruction
	rs_pkg::dispatch_t entry;
	// Source readiness
	logic src1_ok;
	logic src2_ok;
	// CDB hits against the incoming record
	logic hit1_in;
	logic hit2_in;
	// CDB hits against the stored record
	logic hit1;
	logic hit2;

	// ----------------------------------------------------------------------
	// Tag compare
	// ----------------------------------------------------------------------

	// Same-cycle broadcast at dispatch must not be missed
	assign hit1_in = cdb_valid && (cdb_tag == dispatch_in.src1);
	assign hit2_in = cdb_valid && (cdb_tag == dispatch_in.src2);
	assign hit1 = cdb_valid && (cdb_tag == entry.src1);
	assign hit2 = cdb_valid && (cdb_tag == entry.src2);

	// ----------------------------------------------------------------------
	// Row state
	// ----------------------------------------------------------------------

	always_ff @(posedge clock) begin
		if (reset) begin
			busy <= 1'b0;
			src1_ok <= 1'b0;
			src2_ok <= 1'b0;
		end else if (write) begin
			busy <= 1'b1;
			src1_ok <= dispatch_in.src1_ready | hit1_in;
			src2_ok <= dispatch_in.src2_ready | hit2_in;
		end else begin
			// Granted row is free from the next cycle
			if (grant) begin
				busy <= 1'b0;
			end
			// Wakeup only while occupied
			if (busy) begin
				src1_ok <= src1_ok | hit1;
				src2_ok <= src2_ok | hit2;
			end
		end
	end

	// Payload
	always_ff @(posedge clock) begin
		if (write) begin
			entry <= dispatch_in;
		end
	end

	assign ready = busy && src1_ok && src2_ok;
	assign fu = entry.fu;
	assign row = '{opcode: entry.opcode, dest: entry.dest, src1: entry.src1, src2: entry.src2};

endmodule

`default_nettype wire

//--- rtl/rs_dispatch.sv
/*
 * Free-row allocator of the reservation station.
 * Steers a dispatch strobe to the lowest idle row and flags a full station.
 */

`timescale 1ns/10ps
`default_nettype none

`include "rs_config.svh"

module rs_dispatch (
	input  logic        dispatch_valid,
	output logic        rs_full,
	rs_row_if.alloc     rows
);

	// ----------------------------------------------------------------------
	// Free row search
	// ----------------------------------------------------------------------

	// Idle rows, one bit each
	logic [`RS_SIZE-1:0] free_rows;
	// Lowest idle row as a one-hot vector
	logic [`RS_SIZE-1:0] free_pick;

	assign free_rows = ~rows.busy;

	// Two's complement trick isolates the lowest set bit
	assign free_pick = free_rows & (~free_rows + 1'b1);

	// ----------------------------------------------------------------------
	// Write strobe and full flag
	// ----------------------------------------------------------------------

	// No free row means free_pick is zero and the dispatch is dropped
	always_comb begin
		rows.write = '0;
		if (dispatch_valid) begin
			rows.write = free_pick;
		end
	end

	// Full is simply every row busy
	// A row granted this cycle still counts until the next edge
	assign rs_full = &rows.busy;

endmodule

`default_nettype wire

//--- rtl/rs_row_if.sv
/*
 * Per-row vectors of the reservation station.
 * Links the free-row allocator, the entries and the issue selector.
 */

`timescale 1ns/10ps
`default_nettype none

`include "rs_config.svh"

interface rs_row_if;

	// One-hot dispatch write, from the allocator
	logic [`RS_SIZE-1:0] write;
	// Issue grants, at most one row per class
	logic [`RS_SIZE-1:0] grant;
	// Row state, each bit driven by its own entry
	wire [`RS_SIZE-1:0] busy;
	wire [`RS_SIZE-1:0] ready;
	// Class and payload of every row
	isa_pkg::fu_class_t fu [`RS_SIZE];
	rs_pkg::issue_t row [`RS_SIZE];

	modport alloc (input busy, output write);
	modport select (input ready, fu, row, output grant);
	// Entry side of the bundle
	modport rows (input write, grant, output busy, ready, fu, row);

endinterface

`default_nettype wire

//--- rtl/rs_pkg.sv
/*
 * Reservation station records for dispatch and issue.
 * Builds on the instruction-level types of isa_pkg.
 */

`default_nettype none

package rs_pkg;

	// Renamed instruction as handed over by dispatch
	typedef struct packed {
		isa_pkg::fu_class_t fu;
		isa_pkg::opcode_t   opcode;
		isa_pkg::preg_t     dest;
		isa_pkg::preg_t     src1;
		isa_pkg::preg_t     src2;
		logic               src1_ready;
		logic               src2_ready;
	} dispatch_t;

	// Contents of one issue slot, class is implied by the slot
	typedef struct packed {
		isa_pkg::opcode_t opcode;
		isa_pkg::preg_t   dest;
		isa_pkg::preg_t   src1;
		isa_pkg::preg_t   src2;
	} issue_t;

endpackage

`default_nettype wire

//--- rtl/isa_pkg.sv
/*
 * Instruction-level types shared by rename, the station and the units.
 * Referenced by scoped name from the station packages and modules.
 */

`default_nettype none

`include "rs_config.svh"

package isa_pkg;

	// Functional unit class, value doubles as issue slot index
	typedef enum logic [1:0] {
		ALU  = 2'd0,
		MULT = 2'd1,
		MEM  = 2'd2
	} fu_class_t;

	// Opcode is opaque to the station
	typedef logic [7:0] opcode_t;

	// Physical register tag
	typedef logic [`PREG_BITS-1:0] preg_t;

endpackage

`default_nettype wire

//--- include/rs_config.svh
/*
 * Sizing macros for the reservation station.
 * Included by the packages, the row interface and the RTL that needs them.
 */

`ifndef RS_CONFIG_SVH
`define RS_CONFIG_SVH

// Number of station rows
`define RS_SIZE 8

// Functional unit classes, one issue slot each
`define NUM_FU 3

// Physical register tag width
`define PREG_BITS 6

`endif
